/* logic/soc_axi_pkg.sv */
package soc_axi_pkg;

    localparam int AXI_ID_W   = 4;
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    typedef logic [AXI_ID_W-1:0]   axi_id_t;
    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [AXI_DATA_W-1:0] axi_data_t;
    typedef logic [AXI_STRB_W-1:0] axi_strb_t;
    typedef logic [1:0]            axi_resp_t;

    localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

    // Shared by the aw and ar channels
    typedef struct packed {
        axi_id_t   id;
        axi_addr_t addr;
    } axi_ax_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
    } axi_w_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } axi_b_t;

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_t resp;
    } axi_r_t;

endpackage

/* logic/soc_conf_pkg.sv */
package soc_conf_pkg;

    // Low address bits decoded inside the configuration block
    localparam int CONF_OFS_W = 16;

    typedef logic [CONF_OFS_W-1:0] conf_ofs_t;
    typedef logic [15:0]           conf_base_t;

    localparam conf_base_t CONF_BASE = 16'hbfaf;  // Upper address half of the block

    localparam conf_ofs_t CONF_LED_OFS    = 16'h0000;
    localparam conf_ofs_t CONF_SWITCH_OFS = 16'h0004;
    localparam conf_ofs_t CONF_TIMER_OFS  = 16'h0008;

    typedef logic [15:0] led_t;
    typedef logic [7:0]  switch_t;

    // One RAM strobe set with independent read and write sides
    typedef struct packed {
        logic                   ren;
        soc_axi_pkg::axi_addr_t raddr;
        soc_axi_pkg::axi_strb_t wen;
        soc_axi_pkg::axi_addr_t waddr;
        soc_axi_pkg::axi_data_t wdata;
    } ram_req_t;

endpackage

/* logic/soc_axi_sram_bridge.sv */
`timescale 1ns/1ps

module soc_axi_sram_bridge (
    input  logic                   aclk_i,
    input  logic                   rst_i,

    input  soc_axi_pkg::axi_ax_t   aw_i,
    input  logic                   awvalid_i,
    output logic                   awready_o,

    input  soc_axi_pkg::axi_w_t    w_i,
    input  logic                   wvalid_i,
    output logic                   wready_o,

    output soc_axi_pkg::axi_b_t    b_o,
    output logic                   bvalid_o,
    input  logic                   bready_i,

    input  soc_axi_pkg::axi_ax_t   ar_i,
    input  logic                   arvalid_i,
    output logic                   arready_o,

    output soc_axi_pkg::axi_r_t    r_o,
    output logic                   rvalid_o,
    input  logic                   rready_i,

    output soc_conf_pkg::ram_req_t ram_req_o,
    input  soc_axi_pkg::axi_data_t ram_rdata_i
);
    import soc_axi_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_REQ,
        ST_RD_CAP,
        ST_RD_RESP,
        ST_WR_REQ,
        ST_WR_RESP
    } state_t;

    state_t    state_q;
    state_t    state_d;
    logic      wr_go;
    logic      rd_go;
    axi_ax_t   ax_q;     // Address and id of the current transfer
    axi_w_t    w_q;
    axi_data_t rdata_q;

    // Write wins when aw and w are both offered
    assign wr_go = (state_q == ST_IDLE) && awvalid_i && wvalid_i;
    assign rd_go = (state_q == ST_IDLE) && arvalid_i && !wr_go;

    assign awready_o = wr_go;
    assign wready_o  = wr_go;
    assign arready_o = rd_go;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (wr_go) begin
                    state_d = ST_WR_REQ;
                end else if (rd_go) begin
                    state_d = ST_RD_REQ;
                end
            end
            ST_RD_REQ: begin
                state_d = ST_RD_CAP;
            end
            ST_RD_CAP: begin
                state_d = ST_RD_RESP;
            end
            ST_RD_RESP: begin
                if (rready_i) begin
                    state_d = ST_IDLE;
                end
            end
            ST_WR_REQ: begin
                state_d = ST_WR_RESP;
            end
            ST_WR_RESP: begin
                if (bready_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge aclk_i) begin
        if (wr_go) begin
            ax_q <= aw_i;
            w_q  <= w_i;
        end else if (rd_go) begin
            ax_q <= ar_i;
        end
        if (state_q == ST_RD_CAP) begin
            rdata_q <= ram_rdata_i;  // RAM answers one cycle after ren
        end
    end

    always_comb begin
        ram_req_o.ren   = (state_q == ST_RD_REQ);
        ram_req_o.raddr = ax_q.addr;
        ram_req_o.wen   = (state_q == ST_WR_REQ) ? w_q.strb : '0;
        ram_req_o.waddr = ax_q.addr;
        ram_req_o.wdata = w_q.data;
    end

    assign bvalid_o = (state_q == ST_WR_RESP);
    assign b_o      = '{id: ax_q.id, resp: AXI_RESP_OKAY};

    assign rvalid_o = (state_q == ST_RD_RESP);
    assign r_o      = '{id: ax_q.id, data: rdata_q, resp: AXI_RESP_OKAY};

    // Strobes only in the cycle right after their own handshake
    a_ren_after_ar: assert property (@(posedge aclk_i) disable iff (rst_i)
        ram_req_o.ren |-> $past(arvalid_i && arready_o));

    a_wen_after_aw: assert property (@(posedge aclk_i) disable iff (rst_i)
        (|ram_req_o.wen) |-> $past(awvalid_i && wvalid_i && awready_o && wready_o));

    a_r_hold: assert property (@(posedge aclk_i) disable iff (rst_i)
        rvalid_o && !rready_i |=> rvalid_o && $stable(r_o));

endmodule

/* logic/soc_ram_decode.sv */
`timescale 1ns/1ps

module soc_ram_decode (
    input  logic                   aclk_i,
    input  logic                   rst_i,

    input  soc_conf_pkg::ram_req_t ram_req_i,
    output soc_axi_pkg::axi_data_t ram_rdata_o,

    output soc_conf_pkg::ram_req_t sram_req_o,
    input  soc_axi_pkg::axi_data_t sram_rdata_i,

    output soc_conf_pkg::ram_req_t conf_req_o,
    input  soc_axi_pkg::axi_data_t conf_rdata_i
);
    import soc_axi_pkg::*;
    import soc_conf_pkg::*;

    logic rd_conf;
    logic wr_conf;
    logic rd_conf_q;  // Target of the read issued last cycle

    assign rd_conf = (ram_req_i.raddr[AXI_ADDR_W-1:CONF_OFS_W] == CONF_BASE);
    assign wr_conf = (ram_req_i.waddr[AXI_ADDR_W-1:CONF_OFS_W] == CONF_BASE);

    // Payload goes to both sides, only the enables are steered
    always_comb begin
        sram_req_o     = ram_req_i;
        conf_req_o     = ram_req_i;
        sram_req_o.ren = ram_req_i.ren && !rd_conf;
        conf_req_o.ren = ram_req_i.ren && rd_conf;
        sram_req_o.wen = wr_conf ? '0 : ram_req_i.wen;
        conf_req_o.wen = wr_conf ? ram_req_i.wen : '0;
    end

    always_ff @(posedge aclk_i) begin
        if (rst_i) begin
            rd_conf_q <= 1'b0;
        end else if (ram_req_i.ren) begin
            rd_conf_q <= rd_conf;
        end
    end

    assign ram_rdata_o = rd_conf_q ? conf_rdata_i : sram_rdata_i;

    a_one_target: assert property (@(posedge aclk_i) disable iff (rst_i)
        !((sram_req_o.ren || (|sram_req_o.wen)) && (conf_req_o.ren || (|conf_req_o.wen))));

endmodule

/* logic/conf_timer.sv */
`timescale 1ns/1ps

module conf_timer (
    input  logic                   aclk_i,
    input  logic                   rst_i,
    input  logic                   load_i,
    input  soc_axi_pkg::axi_data_t load_value_i,
    output soc_axi_pkg::axi_data_t count_o
);
    import soc_axi_pkg::*;

    axi_data_t count_q;

    always_ff @(posedge aclk_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= load_value_i;  // Software preset
        end else begin
            count_q <= count_q + axi_data_t'(1);  // Wraps at all ones
        end
    end

    assign count_o = count_q;

endmodule

/* logic/confreg.sv */
`timescale 1ns/1ps

module confreg (
    input  logic                   aclk_i,
    input  logic                   rst_i,
    input  soc_conf_pkg::ram_req_t conf_req_i,
    output soc_axi_pkg::axi_data_t conf_rdata_o,
    input  soc_conf_pkg::switch_t  switch_i,
    output soc_conf_pkg::led_t     led_o
);
    import soc_axi_pkg::*;
    import soc_conf_pkg::*;

    conf_ofs_t rd_ofs;
    conf_ofs_t wr_ofs;
    led_t      led_q;
    axi_data_t led_merged;
    axi_data_t timer_cnt;
    axi_data_t timer_load_val;
    logic      timer_load;
    axi_data_t rd_word;
    axi_data_t rdata_q;

    // Replace only the strobed bytes of a word
    function automatic axi_data_t merge_bytes(input axi_data_t old_v,
                                              input axi_data_t new_v,
                                              input axi_strb_t strb);
        axi_data_t res;
        res = old_v;
        for (int i = 0; i < AXI_STRB_W; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = new_v[i*8 +: 8];
            end
        end
        return res;
    endfunction

    assign rd_ofs = conf_req_i.raddr[CONF_OFS_W-1:0];
    assign wr_ofs = conf_req_i.waddr[CONF_OFS_W-1:0];

    assign led_merged     = merge_bytes(axi_data_t'(led_q), conf_req_i.wdata, conf_req_i.wen);
    assign timer_load_val = merge_bytes(timer_cnt, conf_req_i.wdata, conf_req_i.wen);
    assign timer_load     = (wr_ofs == CONF_TIMER_OFS) && (|conf_req_i.wen);

    always_ff @(posedge aclk_i) begin
        if (rst_i) begin
            led_q <= '0;
        end else if ((wr_ofs == CONF_LED_OFS) && (|conf_req_i.wen)) begin
            led_q <= led_t'(led_merged);  // Upper half has no storage
        end
    end

    conf_timer i_timer (
        .aclk_i       (aclk_i),
        .rst_i        (rst_i),
        .load_i       (timer_load),
        .load_value_i (timer_load_val),
        .count_o      (timer_cnt)
    );

    always_comb begin
        case (rd_ofs)
            CONF_LED_OFS:    rd_word = axi_data_t'(led_q);
            CONF_SWITCH_OFS: rd_word = axi_data_t'(switch_i);
            CONF_TIMER_OFS:  rd_word = timer_cnt;
            default:         rd_word = '0;  // Unmapped
        endcase
    end

    always_ff @(posedge aclk_i) begin
        if (conf_req_i.ren) begin
            rdata_q <= rd_word;
        end
    end

    assign conf_rdata_o = rdata_q;
    assign led_o        = led_q;

endmodule

/* logic/soc_top.sv */
`timescale 1ns/1ps

module soc_top (
    input  logic                   aclk_i,
    input  logic                   rst_i,

    input  soc_axi_pkg::axi_ax_t   aw_i,
    input  logic                   awvalid_i,
    output logic                   awready_o,
    input  soc_axi_pkg::axi_w_t    w_i,
    input  logic                   wvalid_i,
    output logic                   wready_o,
    output soc_axi_pkg::axi_b_t    b_o,
    output logic                   bvalid_o,
    input  logic                   bready_i,
    input  soc_axi_pkg::axi_ax_t   ar_i,
    input  logic                   arvalid_i,
    output logic                   arready_o,
    output soc_axi_pkg::axi_r_t    r_o,
    output logic                   rvalid_o,
    input  logic                   rready_i,

    output soc_conf_pkg::ram_req_t sram_req_o,
    input  soc_axi_pkg::axi_data_t sram_rdata_i,

    input  soc_conf_pkg::switch_t  switch_i,
    output soc_conf_pkg::led_t     led_o
);
    import soc_axi_pkg::*;
    import soc_conf_pkg::*;

    ram_req_t  ram_req;    // Bridge side strobes
    axi_data_t ram_rdata;
    ram_req_t  conf_req;
    axi_data_t conf_rdata;

    soc_axi_sram_bridge i_bridge (
        .aclk_i      (aclk_i),
        .rst_i       (rst_i),
        .aw_i        (aw_i),
        .awvalid_i   (awvalid_i),
        .awready_o   (awready_o),
        .w_i         (w_i),
        .wvalid_i    (wvalid_i),
        .wready_o    (wready_o),
        .b_o         (b_o),
        .bvalid_o    (bvalid_o),
        .bready_i    (bready_i),
        .ar_i        (ar_i),
        .arvalid_i   (arvalid_i),
        .arready_o   (arready_o),
        .r_o         (r_o),
        .rvalid_o    (rvalid_o),
        .rready_i    (rready_i),
        .ram_req_o   (ram_req),
        .ram_rdata_i (ram_rdata)
    );

    soc_ram_decode i_decode (
        .aclk_i       (aclk_i),
        .rst_i        (rst_i),
        .ram_req_i    (ram_req),
        .ram_rdata_o  (ram_rdata),
        .sram_req_o   (sram_req_o),
        .sram_rdata_i (sram_rdata_i),
        .conf_req_o   (conf_req),
        .conf_rdata_i (conf_rdata)
    );

    confreg i_confreg (
        .aclk_i       (aclk_i),
        .rst_i        (rst_i),
        .conf_req_i   (conf_req),
        .conf_rdata_o (conf_rdata),
        .switch_i     (switch_i),
        .led_o        (led_o)
    );

endmodule

/* testbench/tb_soc_cases.svh */
`ifndef TB_SOC_CASES_SVH
`define TB_SOC_CASES_SVH

// Columns: write, id, address, data, strobes, switches, check mode, expected value
// The ready delay of a row is drawn when the row runs

typedef enum logic [2:0] {
    CHK_NONE,  // Write with nothing read back
    CHK_EQ,
    CHK_LED,   // led_o equals the low half of the expected value
    CHK_TMR,   // Above the loaded value and below it plus the cycle limit
    CHK_INC    // Above the previous timer read
} chk_t;

typedef struct packed {
    logic      wr;
    axi_id_t   id;
    axi_addr_t addr;
    axi_data_t data;
    axi_strb_t strb;
    switch_t   sw;
    chk_t      chk;
    axi_data_t exp;
} case_t;

localparam int NCASES = 14;

localparam case_t CASES [NCASES] = '{
    '{1'b1, 4'h1, 32'h0000_0010, 32'h1234_5678, 4'hf, 8'h00, CHK_NONE, 32'h0000_0000},
    '{1'b0, 4'h2, 32'h0000_0010, 32'h0000_0000, 4'h0, 8'h00, CHK_EQ,   32'h1234_5678},
    '{1'b1, 4'h3, 32'h0000_0010, 32'haabb_ccdd, 4'h5, 8'h11, CHK_NONE, 32'h0000_0000},
    '{1'b0, 4'h4, 32'h0000_0010, 32'h0000_0000, 4'h0, 8'h11, CHK_EQ,   32'h12bb_56dd},
    '{1'b0, 4'h5, 32'h0000_0040, 32'h0000_0000, 4'h0, 8'h22, CHK_EQ,   32'hc0de_0040},
    '{1'b1, 4'h6, 32'hbfaf_0000, 32'h0000_a5c3, 4'h3, 8'h22, CHK_LED,  32'h0000_a5c3},
    '{1'b0, 4'h7, 32'hbfaf_0000, 32'h0000_0000, 4'h0, 8'h33, CHK_EQ,   32'h0000_a5c3},
    '{1'b0, 4'h8, 32'hbfaf_0004, 32'h0000_0000, 4'h0, 8'ha5, CHK_EQ,   32'h0000_00a5},
    '{1'b0, 4'h9, 32'hbfaf_0010, 32'h0000_0000, 4'h0, 8'hff, CHK_EQ,   32'h0000_0000},
    '{1'b1, 4'ha, 32'hbfaf_0008, 32'h0000_1000, 4'hf, 8'h00, CHK_NONE, 32'h0000_0000},
    '{1'b0, 4'hb, 32'hbfaf_0008, 32'h0000_0000, 4'h0, 8'h00, CHK_TMR,  32'h0000_1000},
    '{1'b0, 4'hc, 32'hbfaf_0008, 32'h0000_0000, 4'h0, 8'h00, CHK_INC,  32'h0000_0000},
    '{1'b1, 4'hd, 32'h0000_03fc, 32'h0f0f_0f0f, 4'hf, 8'h00, CHK_NONE, 32'h0000_0000},
    '{1'b0, 4'he, 32'h0000_03fc, 32'h0000_0000, 4'h0, 8'h00, CHK_EQ,   32'h0f0f_0f0f}
};

`endif

/* testbench/tb_soc_top.sv */
`timescale 1ns/1ps

module tb_soc_top;
    import soc_axi_pkg::*;
    import soc_conf_pkg::*;

    `include "tb_soc_cases.svh"

    localparam int CYCLE_LIMIT = NCASES * 40;

    logic      aclk_i;
    logic      rst_i;
    axi_ax_t   aw_i;
    axi_ax_t   ar_i;
    axi_w_t    w_i;
    axi_b_t    b_o;
    axi_r_t    r_o;
    logic      awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
    logic      awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
    ram_req_t  sram_req_o;
    axi_data_t sram_rdata_i = '0;
    switch_t   switch_i;
    led_t      led_o;

    axi_data_t sram_mem [256];
    int        sram_strobes = 0;  // Every SRAM enable seen so far
    int        cycles = 0;
    int        n_checks;
    int        n_errors;
    integer    seed;

    soc_top i_dut (.*);

    initial begin
        aclk_i = 1'b0;
        forever #50 aclk_i = ~aclk_i;
    end

    // SRAM model with one cycle read latency and byte writes
    always @(posedge aclk_i) begin
        if (rst_i) begin
            for (int i = 0; i < 256; i++) begin
                sram_mem[i] <= 32'hc0de_0000 | axi_data_t'(i << 2);  // Word address as fill
            end
        end else begin
            if (sram_req_o.ren) begin
                sram_rdata_i <= sram_mem[sram_req_o.raddr[9:2]];
            end
            for (int i = 0; i < 4; i++) begin
                if (sram_req_o.wen[i]) begin
                    sram_mem[sram_req_o.waddr[9:2]][i*8 +: 8] <= sram_req_o.wdata[i*8 +: 8];
                end
            end
            if (sram_req_o.ren || (|sram_req_o.wen)) begin
                sram_strobes <= sram_strobes + 1;
            end
        end
    end

    always @(posedge aclk_i) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped, no result after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic ok,
                               input axi_data_t got, input axi_data_t exp);
        n_checks++;
        assert (ok) else begin
            n_errors++;
            $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // One AXI transfer with the ready held low for dly cycles once valid is up
    task automatic transfer(input case_t c, input int unsigned dly,
                            output int lat, output axi_r_t rsp);
        axi_b_t rsp_b;
        @(posedge aclk_i);
        switch_i <= c.sw;
        if (c.wr) begin
            aw_i      <= '{id: c.id, addr: c.addr};
            w_i       <= '{data: c.data, strb: c.strb};
            awvalid_i <= 1'b1;
            wvalid_i  <= 1'b1;
        end else begin
            ar_i      <= '{id: c.id, addr: c.addr};
            arvalid_i <= 1'b1;
        end
        do begin
            @(negedge aclk_i);
        end while (!(awready_o && wready_o) && !arready_o);
        @(posedge aclk_i);  // Handshake edge
        awvalid_i <= 1'b0;
        wvalid_i  <= 1'b0;
        arvalid_i <= 1'b0;
        lat = 0;
        do begin
            @(negedge aclk_i);
            lat++;
        end while (!(c.wr ? bvalid_o : rvalid_o));
        rsp   = r_o;
        rsp_b = b_o;
        repeat (dly) begin
            @(negedge aclk_i);
            check_value("response held under back-pressure",
                        c.wr ? (bvalid_o && b_o == rsp_b) : (rvalid_o && r_o == rsp),
                        r_o.data, rsp.data);
        end
        if (c.wr) begin
            rsp      = '0;
            rsp.id   = rsp_b.id;
            rsp.resp = rsp_b.resp;
        end
        @(posedge aclk_i);
        bready_i <= c.wr;
        rready_i <= !c.wr;
        @(posedge aclk_i);
        bready_i <= 1'b0;
        rready_i <= 1'b0;
    endtask

    initial begin
        case_t       c;
        axi_r_t      rsp;
        int          lat;
        int unsigned dly;
        int          strobes_before;
        axi_data_t   last_timer;
        rst_i     = 1'b1;
        aw_i      = '0;
        w_i       = '0;
        ar_i      = '0;
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        arvalid_i = 1'b0;
        bready_i  = 1'b0;
        rready_i  = 1'b0;
        switch_i  = '0;
        seed      = 59;
        n_checks  = 0;
        n_errors  = 0;
        last_timer = '0;
        repeat (3) @(posedge aclk_i);
        rst_i <= 1'b0;
        @(negedge aclk_i);
        check_value("outputs low after reset",
                    !(rvalid_o || bvalid_o || awready_o || wready_o || arready_o ||
                      sram_req_o.ren || (|sram_req_o.wen)) && (led_o == '0),
                    32'(led_o), 32'h0);
        for (int i = 0; i < NCASES; i++) begin
            c              = CASES[i];
            dly            = $unsigned($random(seed)) % 4;
            strobes_before = sram_strobes;
            transfer(c, dly, lat, rsp);
            check_value("response id", rsp.id == c.id, 32'(rsp.id), 32'(c.id));
            check_value("response code", rsp.resp == AXI_RESP_OKAY,
                        32'(rsp.resp), 32'(AXI_RESP_OKAY));
            check_value("response latency", lat == (c.wr ? 2 : 3),
                        32'(lat), c.wr ? 32'd2 : 32'd3);
            case (c.chk)
                CHK_EQ:  check_value("read data", rsp.data == c.exp, rsp.data, c.exp);
                CHK_LED: check_value("led_o", led_o == c.exp[15:0], 32'(led_o), c.exp);
                CHK_TMR: check_value("timer after load",
                                     (rsp.data > c.exp) && (rsp.data < c.exp + CYCLE_LIMIT),
                                     rsp.data, c.exp);
                CHK_INC: check_value("timer increase", rsp.data > last_timer,
                                     rsp.data, last_timer);
                default: ;
            endcase
            if (!c.wr) begin
                last_timer = rsp.data;
            end
            if (c.addr[31:16] == CONF_BASE) begin
                check_value("SRAM strobe on a config access", sram_strobes == strobes_before,
                            32'(sram_strobes), 32'(strobes_before));
            end
        end
        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+testbench
logic/soc_axi_pkg.sv
logic/soc_conf_pkg.sv
logic/soc_axi_sram_bridge.sv
logic/soc_ram_decode.sv
logic/conf_timer.sv
logic/confreg.sv
logic/soc_top.sv
testbench/tb_soc_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_soc_top
BUILD_DIR ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)
